//--- Bender.yml
package:
  name: taiga_core

sources:
  - include_dirs:
      - .
    files:
      - taiga_types_pkg.sv
      - fetch.sv
      - instruction_buffer.sv
      - register_file.sv
      - decode_issue.sv
      - taiga_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_taiga_core.sv

//--- decode_issue.sv
/*
 * decode, issue and execute for ALU, LUI and JAL
 * one instruction per cycle with a single writeback stage and forwarding
 */

`timescale 1ns/1ps

`include "taiga_cfg.svh"

module decode_issue (
        input logic clk,
        input logic rst_n,

        input logic ib_valid,
        input taiga_types_pkg::fetch_packet_t ib_head,
        output logic ib_pop,

        output logic redirect,
        output logic [31:0] redirect_pc,

        output logic wb_valid,
        output logic [4:0] wb_rd,
        output logic [31:0] wb_data,

        output logic [31:0] dec_pc_debug
        );

    localparam int REG_IDX_W = $clog2(`TAIGA_NUM_REGS);

    logic [31:0] instr;
    logic [31:0] pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] rf_rs1;
    logic [31:0] rf_rs2;
    logic [31:0] op_a;
    logic [31:0] rs2_val;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic writes_rd;
    logic is_jal;
    logic [31:0] dec_pc;
    taiga_types_pkg::alu_op_t alu_op;

    // funct3 plus bit 30 to ALU op, bit 30 only means SUB for reg-reg
    function automatic taiga_types_pkg::alu_op_t func_to_op(input logic [2:0] f3,
            input logic alt, input logic is_reg);
        case (f3)
            3'b000 : return (alt && is_reg) ? taiga_types_pkg::ALU_SUB : taiga_types_pkg::ALU_ADD;
            3'b001 : return taiga_types_pkg::ALU_SLL;
            3'b010 : return taiga_types_pkg::ALU_SLT;
            3'b011 : return taiga_types_pkg::ALU_SLTU;
            3'b100 : return taiga_types_pkg::ALU_XOR;
            3'b101 : return alt ? taiga_types_pkg::ALU_SRA : taiga_types_pkg::ALU_SRL;
            3'b110 : return taiga_types_pkg::ALU_OR;
            default : return taiga_types_pkg::ALU_AND;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign instr = ib_head.instruction;
    assign pc = ib_head.pc;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd_idx = instr[11:7];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign ib_pop = ib_valid; // never stalls

    register_file register_file_block (
        .clk (clk),
        .rst_n (rst_n),
        .rs1_addr (rs1_idx),
        .rs2_addr (rs2_idx),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .we (wb_valid),
        .rd_addr (wb_rd),
        .rd_data (wb_data)
    );

    // wb_valid already implies a non-zero rd
    assign op_a = (wb_valid && wb_rd == rs1_idx) ? wb_data : rf_rs1;
    assign rs2_val = (wb_valid && wb_rd == rs2_idx) ? wb_data : rf_rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        alu_op = taiga_types_pkg::ALU_PASS_B;
        op_b = rs2_val;
        writes_rd = 1'b0;
        is_jal = 1'b0;
        case (opcode)
            taiga_types_pkg::OPCODE_OP : begin
                alu_op = func_to_op(funct3, instr[30], 1'b1);
                writes_rd = 1'b1;
            end
            taiga_types_pkg::OPCODE_OP_IMM : begin
                alu_op = func_to_op(funct3, instr[30], 1'b0); // srai keeps bit 30
                op_b = imm_i; // shamt sits in the low five bits
                writes_rd = 1'b1;
            end
            taiga_types_pkg::OPCODE_LUI : begin
                op_b = imm_u;
                writes_rd = 1'b1;
            end
            taiga_types_pkg::OPCODE_JAL : begin
                op_b = pc + 32'd4; // link value
                writes_rd = 1'b1;
                is_jal = 1'b1;
            end
            default : ; // anything else retires silently
        endcase
    end

    // execute
    always_comb begin
        case (alu_op)
            taiga_types_pkg::ALU_ADD : alu_result = op_a + op_b;
            taiga_types_pkg::ALU_SUB : alu_result = op_a - op_b;
            taiga_types_pkg::ALU_SLL : alu_result = op_a << op_b[4:0];
            taiga_types_pkg::ALU_SLT : alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            taiga_types_pkg::ALU_SLTU : alu_result = {31'd0, op_a < op_b};
            taiga_types_pkg::ALU_XOR : alu_result = op_a ^ op_b;
            taiga_types_pkg::ALU_SRL : alu_result = op_a >> op_b[4:0];
            taiga_types_pkg::ALU_SRA : alu_result = 32'($signed(op_a) >>> op_b[4:0]);
            taiga_types_pkg::ALU_OR : alu_result = op_a | op_b;
            taiga_types_pkg::ALU_AND : alu_result = op_a & op_b;
            default : alu_result = op_b; // pass b
        endcase
    end

    assign redirect = ib_pop & is_jal;
    assign redirect_pc = pc + imm_j;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            dec_pc <= `TAIGA_RESET_PC;
        end else begin
            wb_valid <= ib_pop & writes_rd & (rd_idx != '0); // x0 targets vanish here
            if (ib_pop)
                dec_pc <= pc; // last issued pc
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= rd_idx;
        wb_data <= alu_result;
    end

    assign dec_pc_debug = dec_pc;

    wb_rd_nonzero_a : assert property (@(posedge clk) disable iff (!rst_n)
            wb_valid |-> wb_rd != 5'd0)
        else $error("writeback raised for x0");

endmodule

//--- fetch.sv
/*
 * fetch unit
 * drives the instruction memory request/grant port and pushes returned words
 */

`timescale 1ns/1ps

`include "taiga_cfg.svh"

module fetch (
        input logic clk,
        input logic rst_n,

        // instruction memory
        output logic instr_req,
        output logic [31:0] instr_addr,
        input logic instr_gnt,
        input logic [31:0] instr_rdata,

        // instruction buffer
        input logic ib_room,
        output logic ib_push,
        output taiga_types_pkg::fetch_packet_t ib_push_packet,

        // from decode_issue
        input logic redirect,
        input logic [31:0] redirect_pc
        );

    logic [31:0] pc;      // address of the next request
    logic req_hold;       // request raised but not yet granted
    logic accept;
    logic rsp_pending;    // rdata is valid this cycle
    logic [31:0] rsp_pc;  // address of the word now on rdata
    logic rsp_discard;    // response overtaken by a redirect

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // room means two free slots, so the word already in flight still fits
    assign instr_req = ib_room | req_hold;
    assign instr_addr = pc;
    assign accept = instr_req & instr_gnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `TAIGA_RESET_PC;
            req_hold <= 1'b0;
        end else begin
            if (redirect)
                pc <= redirect_pc; // unaccepted request is dropped
            else if (accept)
                pc <= pc + 32'd4;
            req_hold <= instr_req & ~instr_gnt & ~redirect; // keep asking until granted
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_pending <= 1'b0;
            rsp_discard <= 1'b0;
        end else begin
            rsp_pending <= accept;
            rsp_discard <= accept & redirect; // granted in the redirect cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            rsp_pc <= instr_addr;
    end

    // a word landing in the redirect cycle itself is dropped by the buffer flush
    assign ib_push = rsp_pending & ~rsp_discard;
    assign ib_push_packet.pc = rsp_pc;
    assign ib_push_packet.instruction = instr_rdata;

    // memory sees one stable address per request
    addr_stable_a : assert property (@(posedge clk) disable iff (!rst_n)
            instr_req && !instr_gnt && !redirect |=> instr_req && $stable(instr_addr))
        else $error("fetch dropped or moved an ungranted request");

endmodule

//--- instruction_buffer.sv
/*
 * instruction buffer
 * circular FIFO of fetch packets between fetch and decode_issue
 */

`timescale 1ns/1ps

`include "taiga_cfg.svh"

module instruction_buffer #(
        parameter int DEPTH = `TAIGA_IB_DEPTH
        )(
        input logic clk,
        input logic rst_n,

        input logic flush,
        input logic push,
        input taiga_types_pkg::fetch_packet_t push_packet,
        input logic pop,

        output logic valid,
        output logic room,
        output taiga_types_pkg::fetch_packet_t head
        );

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    taiga_types_pkg::fetch_packet_t entries [DEPTH]; // payload, no reset
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count; // occupied entries
    logic do_push;
    logic do_pop;

    assign do_push = push & ~flush; // flush wins over a same cycle push
    assign do_pop = pop & ~flush;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0; // drops everything, head included
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            case ({do_push, do_pop})
                2'b10 : count <= count + CNT_W'(1);
                2'b01 : count <= count - CNT_W'(1);
                default : count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_packet;
    end

    assign head = entries[rd_ptr];
    assign valid = (count != '0);
    assign room = (count <= CNT_W'(DEPTH - 2)); // at least two slots free

    // fetch only asks for words it can store
    no_overflow_a : assert property (@(posedge clk) disable iff (!rst_n)
            push |-> count != CNT_W'(DEPTH))
        else $error("push into a full instruction buffer");

    no_underflow_a : assert property (@(posedge clk) disable iff (!rst_n)
            pop |-> valid)
        else $error("pop from an empty instruction buffer");

endmodule

//--- register_file.sv
/*
 * integer register file
 * x0 fixed at zero, two asynchronous reads, one synchronous write
 */

`timescale 1ns/1ps

`include "taiga_cfg.svh"

module register_file (
        input logic clk,
        input logic rst_n,

        input logic [4:0] rs1_addr,
        input logic [4:0] rs2_addr,
        output logic [31:0] rs1_data,
        output logic [31:0] rs2_data,

        input logic we,
        input logic [4:0] rd_addr,
        input logic [31:0] rd_data
        );

    logic [31:0] regs [1:`TAIGA_NUM_REGS-1]; // x0 has no storage

    // cleared at reset so every run starts from the same state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `TAIGA_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data; // writes to x0 are lost
        end
    end

    // read ports
    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

//--- taiga_cfg.svh
/*
 * taiga core configuration
 * reset vector, instruction buffer depth and register count
 */

`ifndef TAIGA_CFG_SVH
`define TAIGA_CFG_SVH

// first fetch address out of reset
`define TAIGA_RESET_PC 32'h0000_0000

// default instruction buffer entries, keep at 2 or more
`define TAIGA_IB_DEPTH 4

// architectural integer registers, x0 included
`define TAIGA_NUM_REGS 32

`endif

//--- taiga_core.sv
/*
 * taiga core top level
 * fetch, instruction buffer and decode_issue around one instruction memory port
 */

`timescale 1ns/1ps

module taiga_core (
        input logic clk,
        input logic rst_n,

        // instruction memory
        output logic instr_req,
        output logic [31:0] instr_addr,
        input logic instr_gnt,
        input logic [31:0] instr_rdata,

        // writeback observation
        output logic wb_valid,
        output logic [4:0] wb_rd,
        output logic [31:0] wb_data,

        output logic [31:0] dec_pc_debug
        );

    // fetch to buffer
    logic ib_push;
    logic ib_room;
    taiga_types_pkg::fetch_packet_t ib_push_packet;

    // buffer to decode
    logic ib_valid;
    logic ib_pop;
    taiga_types_pkg::fetch_packet_t ib_head;

    // jal redirect, also the buffer flush
    logic redirect;
    logic [31:0] redirect_pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // front end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch fetch_block (
        .clk (clk),
        .rst_n (rst_n),
        .instr_req (instr_req),
        .instr_addr (instr_addr),
        .instr_gnt (instr_gnt),
        .instr_rdata (instr_rdata),
        .ib_room (ib_room),
        .ib_push (ib_push),
        .ib_push_packet (ib_push_packet),
        .redirect (redirect),
        .redirect_pc (redirect_pc)
    );

    instruction_buffer inst_buffer (
        .clk (clk),
        .rst_n (rst_n),
        .flush (redirect),
        .push (ib_push),
        .push_packet (ib_push_packet),
        .pop (ib_pop),
        .valid (ib_valid),
        .room (ib_room),
        .head (ib_head)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode, execute, writeback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    decode_issue decode_issue_block (
        .clk (clk),
        .rst_n (rst_n),
        .ib_valid (ib_valid),
        .ib_head (ib_head),
        .ib_pop (ib_pop),
        .redirect (redirect),
        .redirect_pc (redirect_pc),
        .wb_valid (wb_valid),
        .wb_rd (wb_rd),
        .wb_data (wb_data),
        .dec_pc_debug (dec_pc_debug)
    );

endmodule

//--- taiga_trace.txt
# I <word address> <instruction word>, hex program image
# W <rd> <data>, hex writebacks in retirement order; S <byte pc> never issues
I 00 00500093
I 01 ffd00113
I 02 002081b3
I 03 40100233
I 04 001122b3
I 05 00113333
I 06 401153b3
I 07 00115433
I 08 001094b3
I 09 0020c533
I 0a 0020e5b3
I 0b 0020f633
I 0c 800016b7
I 0d fff68693
I 0e 4046d713
I 0f 00072793
I 10 00708013
I 11 001008b3
I 12 00c0096f
I 13 00100993
I 14 00200a13
I 15 fff8ca93
I 16 004a9b13
I 17 01cb5b93
I 18 700bec13
I 19 0f0c7c93
I 1a 0ff0000f
I 1b 0000006f
S 0000004c
S 00000050
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffffb
W 05 00000001
W 06 00000000
W 07 ffffffff
W 08 07ffffff
W 09 000000a0
W 0a fffffff8
W 0b fffffffd
W 0c 00000005
W 0d 80001000
W 0d 80000fff
W 0e f80000ff
W 0f 00000001
W 11 00000005
W 12 0000004c
W 15 fffffffa
W 16 ffffffa0
W 17 0000000f
W 18 0000070f
W 19 00000000

//--- taiga_types_pkg.sv
/*
 * taiga shared types
 * fetch packet, ALU operation encoding and RV32I opcode values
 */

package taiga_types_pkg;

    // one fetched word with the address it came from
    typedef struct packed {
        logic [31:0] pc;          // byte address of the word
        logic [31:0] instruction; // raw RV32I encoding
    } fetch_packet_t;

    // ALU operations handled by decode_issue
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // lui immediate and jal link value
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes, instruction bits [6:0]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] OPCODE_OP     = 7'b0110011; // reg-reg alu
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011; // reg-imm alu
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;

endpackage

//--- tb_clock_gen.sv
/*
 * testbench clock and reset
 * free running clock, reset held low for a fixed number of cycles
 */

`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD = 4,        // ns
        parameter int RESET_CYCLES = 10
        )(
        output logic clk,
        output logic rst_n
        );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a rising edge so the first active edge comes one period later
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_taiga_core.sv
/*
 * taiga core testbench
 * runs the trace program from a stalling instruction memory and checks every writeback
 */

`timescale 1ns/1ps

module tb_taiga_core;

    localparam int MEM_WORDS = 256;

    logic clk;
    logic rst_n;
    logic instr_req;
    logic [31:0] instr_addr;
    logic instr_gnt;
    logic [31:0] instr_rdata;
    logic wb_valid;
    logic [4:0] wb_rd;
    logic [31:0] wb_data;
    logic [31:0] dec_pc_debug;

    logic [31:0] imem [MEM_WORDS]; // program image, word indexed
    logic [4:0] exp_rd [$];        // expected writebacks in retirement order
    logic [31:0] exp_data [$];
    logic [31:0] skip_pc [$];      // pcs that must never issue
    int wb_count = 0;
    int wb_total = 0;
    bit trace_loaded = 1'b0;
    bit all_matched = 1'b0;
    integer seed;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(10)) clock_gen_block (
        .clk (clk),
        .rst_n (rst_n)
    );

    taiga_core taiga_core_inst (
        .clk (clk),
        .rst_n (rst_n),
        .instr_req (instr_req),
        .instr_addr (instr_addr),
        .instr_gnt (instr_gnt),
        .instr_rdata (instr_rdata),
        .wb_valid (wb_valid),
        .wb_rd (wb_rd),
        .wb_data (wb_data),
        .dec_pc_debug (dec_pc_debug)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // unsupported custom-0 opcode, tagged with the word index
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = {i[24:0], 7'b0001011};
    endtask

    task automatic load_trace();
        int fd;
        int n;
        string line;
        logic [7:0] tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("taiga_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file taiga_trace.txt");
            $display("Errors found");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", tag, a, b);
            if (tag == "I" && n == 3) begin
                imem[a] = b; // a is a word address
            end else if (tag == "W" && n == 3) begin
                exp_rd.push_back(a[4:0]);
                exp_data.push_back(b);
            end else if (tag == "S" && n >= 2) begin
                skip_pc.push_back(a);
            end
        end
        $fclose(fd);
    endtask

    // label for error lines
    function automatic string opcode_name(input logic [31:0] word);
        case (word[6:0])
            taiga_types_pkg::OPCODE_OP : return "op";
            taiga_types_pkg::OPCODE_OP_IMM : return "op_imm";
            taiga_types_pkg::OPCODE_LUI : return "lui";
            taiga_types_pkg::OPCODE_JAL : return "jal";
            default : return "other";
        endcase
    endfunction

    function automatic bit is_skipped(input logic [31:0] pc);
        foreach (skip_pc[i])
            if (skip_pc[i] == pc)
                return 1'b1;
        return 1'b0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst_n) begin
            instr_gnt <= 1'b0;
        end else begin
            if (instr_req && instr_gnt)
                instr_rdata <= imem[instr_addr[9:2]]; // data one cycle after grant
            instr_gnt <= (($random(seed) & 3) != 0); // grant about 3 cycles in 4
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : wb_monitor
        string label;
        if (rst_n && trace_loaded && wb_valid) begin
            if (wb_count >= wb_total) begin
                $display("unexpected writeback to x%0d after the last trace entry", wb_rd);
                $display("Errors found");
                $fatal(1);
            end else begin
                // dec_pc_debug holds the pc of the instruction now writing back
                label = $sformatf("%s at 0x%08h", opcode_name(imem[dec_pc_debug[9:2]]),
                        dec_pc_debug);
                check_value({label, " rd"}, {27'd0, exp_rd[wb_count]}, {27'd0, wb_rd});
                check_value({label, " data"}, exp_data[wb_count], wb_data);
                wb_count++;
                if (wb_count == wb_total)
                    all_matched = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : skip_monitor
        if (rst_n && trace_loaded && is_skipped(dec_pc_debug)) begin
            $display("instruction at 0x%08h issued although a jump skips it", dec_pc_debug);
            $display("Errors found");
            $fatal(1);
        end
    end

    // limit scales with the number of expected writebacks
    initial begin : watchdog
        wait (trace_loaded);
        repeat (40 * wb_total + 100) @(posedge clk);
        if (!all_matched) begin
            $display("writebacks stopped after %0d of %0d trace entries", wb_count, wb_total);
            $display("Errors found");
            $fatal(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main flow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main_flow
        seed = 32'h3676_a25b;
        instr_gnt = 1'b0;
        instr_rdata = '0;
        fill_memory();
        load_trace();
        wb_total = exp_rd.size();
        all_matched = (wb_total == 0);
        trace_loaded = 1'b1;
        wait (all_matched);
        repeat (20) @(posedge clk); // catch stray writebacks
        $display("No errors");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
taiga_types_pkg.sv
fetch.sv
instruction_buffer.sv
register_file.sv
decode_issue.sv
taiga_core.sv
tb_clock_gen.sv
tb_taiga_core.sv
